// File: Bender.yml
package:
  name: fetch_sys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/imem_pkg.sv
      - rtl/instr_mem.sv
      - rtl/wb_imem_port.sv
      - rtl/fetch_unit.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_fetch_top.sv

// File: fetch_sys.f
+incdir+rtl
rtl/imem_pkg.sv
rtl/instr_mem.sv
rtl/wb_imem_port.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
tests/tb_fetch_top.sv

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top
  import imem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  logic       run,
  input  logic       redir_valid,
  input  imem_addr_t redir_pc,
  output logic       out_valid,
  output fetch_pkt_t out_pkt,
  input  logic       out_ready
);

  imem_req_t  fetch_req;
  imem_req_t  mem_req;
  imem_word_t rdata;
  logic       fetch_gnt;

  instr_mem u_instr_mem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  wb_imem_port u_wb_imem_port (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .fetch_req (fetch_req),
    .fetch_gnt (fetch_gnt),
    .mem_req   (mem_req),
    .rdata     (rdata)
  );

  fetch_unit u_fetch_unit (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .redir_valid (redir_valid),
    .redir_pc    (redir_pc),
    .fetch_req   (fetch_req),
    .fetch_gnt   (fetch_gnt),
    .rdata       (rdata),
    .out_valid   (out_valid),
    .out_pkt     (out_pkt),
    .out_ready   (out_ready)
  );

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns
`include "imem_defs.svh"

module fetch_unit
  import imem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       run,
  input  logic       redir_valid,
  input  imem_addr_t redir_pc,
  output imem_req_t  fetch_req,
  input  logic       fetch_gnt,
  input  imem_word_t rdata,
  output logic       out_valid,
  output fetch_pkt_t out_pkt,
  input  logic       out_ready
);

  imem_addr_t pc_q;         // next address to read.
  imem_addr_t pkt_pc_q;     // address of the read behind the output packet.
  imem_word_t instr_q;
  logic       out_valid_q;
  logic       fresh_q;      // rdata belongs to the read issued last cycle.
  logic       want;
  logic       issue;
  logic       consume;

  assign consume = out_valid_q && out_ready;

  // only read when the output register will be free next cycle.
  assign want  = run && !redir_valid && (!out_valid_q || out_ready);
  assign issue = want && fetch_gnt;

  always_comb begin
    fetch_req       = '0;
    fetch_req.en    = want;
    fetch_req.read  = want;
    fetch_req.write = 1'b0;
    fetch_req.addr  = pc_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= imem_addr_t'(`IMEM_RESET_PC);
      out_valid_q <= 1'b0;
      fresh_q     <= 1'b0;
    end else if (redir_valid) begin
      pc_q        <= redir_pc;  // drop whatever is in flight or waiting.
      out_valid_q <= 1'b0;
      fresh_q     <= 1'b0;
    end else begin
      fresh_q <= issue;
      if (issue) begin
        pc_q        <= pc_q + 1'b1;
        out_valid_q <= 1'b1;
      end else if (consume) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Capture the word on arrival. A later bus read overwrites rdata while
  // the packet may still be waiting.
  always_ff @(posedge clk) begin
    if (issue) begin
      pkt_pc_q <= pc_q;
    end
    if (fresh_q) begin
      instr_q <= rdata;
    end
  end

  assign out_valid     = out_valid_q;
  assign out_pkt.pc    = pkt_pc_q;
  assign out_pkt.instr = fresh_q ? rdata : instr_q;

  // a stalled packet holds, even across bus reads that reuse the memory.
  property p_hold_stalled;
    @(posedge clk) disable iff (rst)
      (out_valid && !out_ready && !redir_valid) |=> (out_valid && $stable(out_pkt));
  endproperty

  a_hold_stalled : assert property (p_hold_stalled)
    else $error("fetch_unit: stalled packet changed at pc 0x%0h", out_pkt.pc);

endmodule

// File: rtl/imem_defs.svh
`ifndef IMEM_DEFS_SVH
`define IMEM_DEFS_SVH

// word address width of the instruction memory.
`define IMEM_ADDR_W 10

// instruction word width.
`define IMEM_DATA_W 32

// number of words held by the memory.
`define IMEM_DEPTH (1 << `IMEM_ADDR_W)

// word address where fetch starts after reset.
`define IMEM_RESET_PC 0

`endif

// File: rtl/imem_pkg.sv
`include "imem_defs.svh"

package imem_pkg;

  typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;  // word address.
  typedef logic [`IMEM_DATA_W-1:0] imem_word_t;  // one instruction.

  // single-port memory request.
  typedef struct packed {
    logic       en;
    logic       read;
    logic       write;
    imem_addr_t addr;
    imem_word_t wdata;
  } imem_req_t;

  // wishbone classic request from master to slave.
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    imem_addr_t adr;
    imem_word_t dat;
  } wb_req_t;

  // wishbone classic response from slave to master.
  typedef struct packed {
    logic       ack;
    imem_word_t dat;
  } wb_rsp_t;

  // packet handed to decode.
  typedef struct packed {
    imem_addr_t pc;
    imem_word_t instr;
  } fetch_pkt_t;

endpackage

// File: rtl/instr_mem.sv
`timescale 1ns/1ns
`include "imem_defs.svh"

module instr_mem
  import imem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  imem_req_t  mem_req,
  output imem_word_t rdata
);

  localparam int DEPTH = `IMEM_DEPTH;

  imem_word_t mem [0:DEPTH-1];
  imem_word_t rdata_q;

  // whole array is wiped on reset, so a program must be reloaded afterwards.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_q <= '0;
    end else if (mem_req.en) begin
      if (mem_req.read) begin
        rdata_q <= mem[mem_req.addr];  // registered read.
      end else if (mem_req.write) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end
    end
  end

  assign rdata = rdata_q;  // holds until the next read.

  // the arbiter upstream must never merge a bus write with a fetch read.
  property p_no_rw_collision;
    @(posedge clk) disable iff (rst)
      mem_req.en |-> !(mem_req.read && mem_req.write);
  endproperty

  a_no_rw_collision : assert property (p_no_rw_collision)
    else $error("instr_mem: read and write requested together at 0x%0h", mem_req.addr);

endmodule

// File: rtl/wb_imem_port.sv
`timescale 1ns/1ns

module wb_imem_port
  import imem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  imem_req_t  fetch_req,
  output logic       fetch_gnt,
  output imem_req_t  mem_req,
  input  imem_word_t rdata
);

  logic bus_acc;    // bus transfer takes the memory port this cycle.
  logic ack_q;
  logic rd_pend_q;  // bus read data is on rdata this cycle.

  // a transfer is taken once; the ack cycle itself is not a new request.
  assign bus_acc = wb_req.cyc && wb_req.stb && !ack_q;

  // fetch only gets the port while the bus is idle and no bus read is returning.
  assign fetch_gnt = !wb_req.cyc && !rd_pend_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q     <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      ack_q     <= bus_acc;
      rd_pend_q <= bus_acc && !wb_req.we;
    end
  end

  always_comb begin
    mem_req = '0;
    if (bus_acc) begin
      mem_req.en    = 1'b1;
      mem_req.read  = !wb_req.we;
      mem_req.write = wb_req.we;
      mem_req.addr  = wb_req.adr;
      mem_req.wdata = wb_req.dat;
    end else if (fetch_gnt) begin
      mem_req = fetch_req;  // fetch owns the port.
    end
  end

  always_comb begin
    wb_rsp.ack = ack_q;
    wb_rsp.dat = rd_pend_q ? rdata : '0;  // write acks carry no data.
  end

  // ack must land inside the strobe of the transfer it answers.
  property p_ack_in_cycle;
    @(posedge clk) disable iff (rst)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb);
  endproperty

  a_ack_in_cycle : assert property (p_ack_in_cycle)
    else $error("wb_imem_port: ack without an open strobe");

endmodule

// File: tests/tb_fetch_top.sv
`timescale 1ns/1ns
`include "imem_defs.svh"

module tb_fetch_top
  import imem_pkg::*;
();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int CLEAR_READS    = 8;
  localparam int LOAD_WORDS     = 64;
  localparam int SEQ_PKTS       = 40;
  localparam int BP_PKTS        = 60;
  localparam int REDIRECTS      = 6;
  localparam int PKTS_PER_REDIR = 8;
  localparam int BUS_PAUSES     = 12;
  localparam int PKTS_PER_PAUSE = 3;
  localparam int BUS_XFERS      = CLEAR_READS + 2 * LOAD_WORDS + BUS_PAUSES;
  localparam int PACKETS        = SEQ_PKTS + BP_PKTS + REDIRECTS * PKTS_PER_REDIR
                                  + BUS_PAUSES * PKTS_PER_PAUSE;

  logic       clk;
  logic       rst;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       run;
  logic       redir_valid;
  imem_addr_t redir_pc;
  logic       out_valid;
  fetch_pkt_t out_pkt;
  logic       out_ready;

  imem_word_t  shadow [0:`IMEM_DEPTH-1];  // every word written over the bus.
  imem_addr_t  exp_pc;                    // pc the next accepted packet must carry.
  int          accepted;
  logic [31:0] rng_state;
  string       test_name;

  fetch_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .run         (run),
    .redir_valid (redir_valid),
    .redir_pc    (redir_pc),
    .out_valid   (out_valid),
    .out_pkt     (out_pkt),
    .out_ready   (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
      stop_failed();
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // one classic transfer; cyc and stb stay up through the ack edge.
  task automatic bus_xfer(input logic we, input imem_addr_t adr, input imem_word_t dat,
                          output imem_word_t rd);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < 8);
    check_value("ack latency", 1, waited);
    rd = wb_rsp.dat;
    @(negedge clk);
    wb_req = '0;
  endtask

  task automatic run_until(input int n, input logic random_ready);
    int          target;
    int          cycles;
    logic [31:0] r;
    target = accepted + n;
    cycles = 0;
    while (accepted < target && cycles <= n * 20) begin
      r = next_rand();
      out_ready = random_ready ? (r[1:0] != 2'b00) : 1'b1;
      @(negedge clk);
      cycles++;
    end
    if (accepted < target) begin
      $display("%s: fetch stopped delivering packets after %0d cycles", test_name, cycles);
      stop_failed();
    end
  endtask

  // reference model of the fetch stream.
  always @(posedge clk) begin
    if (rst) begin
      exp_pc   <= imem_addr_t'(`IMEM_RESET_PC);
      accepted <= 0;
    end else if (redir_valid) begin
      exp_pc <= redir_pc;
    end else if (out_valid && out_ready) begin
      check_value("fetch pc", exp_pc, out_pkt.pc);
      check_value("fetch instr", shadow[exp_pc], out_pkt.instr);
      exp_pc   <= exp_pc + 1'b1;
      accepted <= accepted + 1;
    end
  end

  a_ack_next_cycle : assert property (
    @(posedge clk) disable iff (rst)
      (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else begin
      $display("CHECK FAILED %s ack: expected 1 actual 0", test_name);
      stop_failed();
    end

  a_stall_hold : assert property (
    @(posedge clk) disable iff (rst)
      (out_valid && !out_ready && !redir_valid) |=> (out_valid && $stable(out_pkt)))
    else begin
      $display("%s: a waiting packet changed or vanished while stalled", test_name);
      stop_failed();
    end

  initial begin
    #((BUS_XFERS + PACKETS) * 20 * CLK_PERIOD);
    $display("watchdog expired during %s", test_name);
    stop_failed();
  end

  initial begin
    logic [31:0] r;
    imem_addr_t  addr;
    imem_word_t  rd;
    rst         = 1'b1;
    wb_req      = '0;
    run         = 1'b0;
    redir_valid = 1'b0;
    redir_pc    = '0;
    out_ready   = 1'b0;
    rng_state   = 32'd65643;
    test_name   = "reset_clear";
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_value("out_valid", 0, out_valid);
    check_value("ack", 0, wb_rsp.ack);
    for (int k = 0; k < CLEAR_READS; k++) begin
      r    = next_rand();
      addr = r[`IMEM_ADDR_W-1:0];
      bus_xfer(1'b0, addr, '0, rd);
      check_value("bus read", shadow[addr], rd);
    end

    test_name = "load_readback";
    for (int k = 0; k < LOAD_WORDS; k++) begin
      shadow[k] = next_rand();
      bus_xfer(1'b1, imem_addr_t'(k), shadow[k], rd);
    end
    for (int k = 0; k < LOAD_WORDS; k++) begin
      bus_xfer(1'b0, imem_addr_t'(k), '0, rd);
      check_value("bus read", shadow[k], rd);
    end

    test_name = "seq_fetch";
    run = 1'b1;
    run_until(SEQ_PKTS, 1'b0);

    test_name = "backpressure";
    run_until(BP_PKTS, 1'b1);

    test_name = "redirect";
    for (int k = 0; k < REDIRECTS; k++) begin
      r           = next_rand();
      out_ready   = 1'b0;  // nothing is taken in the redirect cycle.
      redir_valid = 1'b1;
      redir_pc    = imem_addr_t'(r[5:0]);
      @(negedge clk);
      redir_valid = 1'b0;
      run_until(PKTS_PER_REDIR, 1'b1);
    end

    test_name = "bus_during_fetch";
    for (int k = 0; k < BUS_PAUSES; k++) begin
      r         = next_rand();
      addr      = imem_addr_t'(r[5:0]);
      out_ready = 1'b0;  // the fetched packet waits while the bus read reuses rdata.
      bus_xfer(1'b0, addr, '0, rd);
      check_value("bus read", shadow[addr], rd);
      run_until(PKTS_PER_PAUSE, 1'b0);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule
